/* testbench/rd_mux_patterns.txt */
# test port addr prot rdata rresp stall, all hex except test, port and stall
# stall: cycles the master waits before serving the read (AR ready in test 6, R valid otherwise)
2 0 00001000 0 11110000 0 0
2 1 00002004 2 22220001 1 2
2 2 00003008 5 33330002 2 0
2 3 0000400c 7 44440003 3 1
3 0 00010000 1 a0000000 0 0
3 1 00011000 2 a1000000 0 0
3 2 00012000 3 a2000000 0 0
3 3 00013000 4 a3000000 0 0
3 0 00010004 5 a0000004 1 0
3 1 00011004 6 a1000004 0 0
3 2 00012004 7 a2000004 2 0
3 3 00013004 0 a3000004 0 0
4 0 00020000 0 b0000000 0 0
4 0 00020004 1 b0000004 1 0
4 0 00020008 2 b0000008 0 0
4 1 00021000 3 b1000000 2 0
4 1 00021004 4 b1000004 0 0
4 2 00022000 5 b2000000 3 0
4 3 00023000 6 b3000000 0 0
4 3 00023004 7 b3000004 1 0
5 0 00030000 0 c0000000 0 30
5 1 00031000 1 c1000000 0 0
5 2 00032000 2 c2000000 1 0
5 3 00033000 3 c3000000 0 0
5 0 00030004 4 c0000004 2 0
5 1 00031004 5 c1000004 0 0
6 0 00040000 1 d0000000 0 12
6 1 00041000 2 d1000000 0 0
6 2 00042000 3 d2000000 3 6
6 3 00043000 4 d3000000 0 3

/* files.f */
rtl/lite_mux_pkg.sv
rtl/ar_chan_if.sv
rtl/ar_rr_arbiter.sv
rtl/rd_order_tracker.sv
rtl/ar_spill_reg.sv
rtl/lite_rd_mux.sv
testbench/tb_lite_rd_mux.sv

/* Bender.yml */
package:
  name: lite_rd_mux

sources:
  - files:
      - rtl/lite_mux_pkg.sv
      - rtl/ar_chan_if.sv
      - rtl/ar_rr_arbiter.sv
      - rtl/rd_order_tracker.sv
      - rtl/ar_spill_reg.sv
      - rtl/lite_rd_mux.sv
  - target: test
    files:
      - testbench/tb_lite_rd_mux.sv

/* testbench/tb_lite_rd_mux.sv */
/*
  Testbench for the AXI4-Lite read multiplexer.
  Reads testbench/rd_mux_patterns.txt relative to the project root.
  Pattern addresses must be unique, since the responder looks data up by address.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_lite_rd_mux;
  import lite_mux_pkg::*;

  localparam int FIELDS       = 7;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_TIMEOUT  = 600;
  localparam int MAX_LINES    = 1000;
  localparam int NUM_TESTS    = 6;

  logic      clk;
  logic      reset;
  port_vec_t slv_ar_valid;
  addr_t     slv_ar_addr [NUM_PORTS];
  prot_t     slv_ar_prot [NUM_PORTS];
  port_vec_t slv_ar_ready;
  port_vec_t slv_r_valid;
  data_t     slv_r_data;
  rresp_t    slv_r_resp;
  port_vec_t slv_r_ready;
  logic      mst_ar_valid;
  addr_t     mst_ar_addr;
  prot_t     mst_ar_prot;
  logic      mst_ar_ready;
  logic      mst_r_valid;
  data_t     mst_r_data;
  rresp_t    mst_r_resp;
  logic      mst_r_ready;

  // Pattern table, one entry per data line
  int     pat_test [$];
  int     pat_port [$];
  addr_t  pat_addr [$];
  prot_t  pat_prot [$];
  data_t  pat_data [$];
  rresp_t pat_resp [$];
  int     pat_stall [$];

  // Scoreboard, all entries are pattern indices
  int req_q [NUM_PORTS][$];
  int exp_q [NUM_PORTS][$];
  int iss_q [$];
  int resp_q [$];
  int ar_port_seq [$];

  int err_cnt;
  int check_cnt;
  int fail_tests;

  lite_rd_mux lite_rd_mux_i (
    .clk_i          (clk),
    .reset_i        (reset),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_addr_i  (slv_ar_addr),
    .slv_ar_prot_i  (slv_ar_prot),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_valid_o  (slv_r_valid),
    .slv_r_data_o   (slv_r_data),
    .slv_r_resp_o   (slv_r_resp),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_addr_o  (mst_ar_addr),
    .mst_ar_prot_o  (mst_ar_prot),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_data_i   (mst_r_data),
    .mst_r_resp_i   (mst_r_resp),
    .mst_r_ready_o  (mst_r_ready)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  function automatic int find_addr(input addr_t a);
    int i;
    for (i = 0; i < pat_addr.size(); i++) begin
      if (pat_addr[i] == a) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "reset";
      2:       return "single reads";
      3:       return "fairness";
      4:       return "ordering under back-pressure";
      5:       return "outstanding limit";
      6:       return "AR stall stability";
      default: return "unknown";
    endcase
  endfunction

  // ------------------------------
  // Pattern file
  // ------------------------------
  task automatic load_patterns();
    int          fd;
    int          n;
    int          lines;
    int          t;
    int          p;
    int          st;
    logic [31:0] a;
    logic [31:0] pr;
    logic [31:0] d;
    logic [31:0] rs;
    string       line;
    fd = $fopen("testbench/rd_mux_patterns.txt", "r");
    if (fd == 0) begin
      note_failure("could not open the pattern file testbench/rd_mux_patterns.txt");
      return;
    end
    lines = 0;
    while (!$feof(fd) && lines < MAX_LINES) begin
      lines++;
      line = "";
      n = $fgets(line, fd);
      // Lines starting with # hold column notes
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%d %d %h %h %h %h %d", t, p, a, pr, d, rs, st);
        if (n == FIELDS && p >= 0 && p < NUM_PORTS) begin
          pat_test.push_back(t);
          pat_port.push_back(p);
          pat_addr.push_back(a);
          pat_prot.push_back(prot_t'(pr));
          pat_data.push_back(d);
          pat_resp.push_back(rresp_t'(rs));
          pat_stall.push_back(st);
        end else if (n > 0) begin
          note_failure($sformatf("pattern file line %0d could not be read", lines));
        end
      end
    end
    $fclose(fd);
    if (pat_test.size() == 0) begin
      note_failure("the pattern file held no usable lines");
    end
  endtask

  task automatic drive_idle();
    int p;
    slv_ar_valid = '0;
    for (p = 0; p < NUM_PORTS; p++) begin
      slv_ar_addr[p] = '0;
      slv_ar_prot[p] = '0;
    end
    slv_r_ready  = '0;
    mst_ar_ready = 1'b0;
    mst_r_valid  = 1'b0;
    mst_r_data   = '0;
    mst_r_resp   = '0;
  endtask

  task automatic check_idle_outputs();
    check_val(mst_ar_valid, 1'b0, "master AR valid not low in reset");
    check_val(slv_ar_ready, '0, "port AR ready not low in reset");
    check_val(slv_r_valid, '0, "port R valid not low in reset");
    check_val(mst_r_ready, 1'b0, "master R ready not low in reset");
  endtask

  // 16 edges with reset high, then two idle cycles
  task automatic apply_reset();
    int c;
    for (c = 0; c <= RESET_CYCLES + 2; c++) begin
      @(posedge clk);
      #1;
      if (c == 0) begin
        reset = 1'b1;
        drive_idle();
      end
      if (c == RESET_CYCLES) begin
        reset = 1'b0;
      end
      #2;
      if (c >= 1) begin
        check_idle_outputs();
      end
    end
  endtask

  // ------------------------------
  // One test from the pattern table
  // ------------------------------
  task automatic run_test(input int test_no);
    int        gap [NUM_PORTS];
    port_vec_t taken;
    port_vec_t exp_rv;
    port_vec_t seen;
    logic      r_taken;
    logic      stalled;
    addr_t     last_addr;
    prot_t     last_prot;
    logic      rnd;
    logic      ar_mode;
    logic      serial;
    logic      allow;
    int        cycle;
    int        pending;
    int        inflight;
    int        r_wait;
    int        r_gap;
    int        ar_wait;
    int        outstanding;
    int        max_out;
    int        idx;
    int        p;

    rnd     = (test_no == 4);
    ar_mode = (test_no == 6);
    serial  = (test_no == 2);
    iss_q.delete();
    resp_q.delete();
    ar_port_seq.delete();
    for (p = 0; p < NUM_PORTS; p++) begin
      req_q[p].delete();
      exp_q[p].delete();
      gap[p] = 0;
    end
    pending = 0;
    for (idx = 0; idx < pat_test.size(); idx++) begin
      if (pat_test[idx] == test_no) begin
        req_q[pat_port[idx]].push_back(idx);
        pending++;
      end
    end
    taken       = '0;
    r_taken     = 1'b0;
    stalled     = 1'b0;
    last_addr   = '0;
    last_prot   = '0;
    inflight    = 0;
    r_wait      = 0;
    r_gap       = 0;
    ar_wait     = 0;
    outstanding = 0;
    max_out     = 0;
    cycle       = 0;

    while (pending > 0 && cycle < RUN_TIMEOUT) begin
      cycle++;
      @(posedge clk);
      #1;
      // Requesters, one read at a time in serial mode
      allow = !serial || (slv_ar_valid == '0 && inflight == 0);
      for (p = 0; p < NUM_PORTS; p++) begin
        if (taken[p]) begin
          slv_ar_valid[p] = 1'b0;
          gap[p] = rnd ? int'($urandom % 3) : 0;
        end
        if (!slv_ar_valid[p] && req_q[p].size() > 0 && allow) begin
          if (gap[p] > 0) begin
            gap[p]--;
          end else begin
            slv_ar_valid[p] = 1'b1;
            slv_ar_addr[p]  = pat_addr[req_q[p][0]];
            slv_ar_prot[p]  = pat_prot[req_q[p][0]];
            allow = !serial;
          end
        end
      end
      // Master AR ready, held off by the stall column in test 6
      if (ar_mode) begin
        idx = find_addr(mst_ar_addr);
        mst_ar_ready = mst_ar_valid && (idx < 0 || ar_wait >= pat_stall[idx]);
      end else begin
        mst_ar_ready = rnd ? (($urandom % 4) != 0) : 1'b1;
      end
      // Responder, R beats in AR order
      if (r_taken) begin
        mst_r_valid = 1'b0;
        r_gap = rnd ? int'($urandom % 4) : 0;
      end
      if (!mst_r_valid && resp_q.size() > 0) begin
        if (r_wait >= r_gap + (ar_mode ? 0 : pat_stall[resp_q[0]])) begin
          mst_r_valid = 1'b1;
          mst_r_data  = pat_data[resp_q[0]];
          mst_r_resp  = pat_resp[resp_q[0]];
        end
      end
      slv_r_ready = rnd ? port_vec_t'($urandom) : {NUM_PORTS{1'b1}};
      taken   = '0;
      r_taken = 1'b0;

      // Sample just before the next edge
      #2;
      if (stalled) begin
        check_val(mst_ar_valid, 1'b1, "master AR valid dropped while stalled");
        check_val(mst_ar_addr, last_addr, "master AR addr changed while stalled");
        check_val(mst_ar_prot, last_prot, "master AR prot changed while stalled");
      end
      stalled   = mst_ar_valid && !mst_ar_ready;
      last_addr = mst_ar_addr;
      last_prot = mst_ar_prot;

      // Master AR goes out in grant order
      if (mst_ar_valid && mst_ar_ready) begin
        ar_wait = 0;
        outstanding++;
        if (iss_q.size() == 0) begin
          note_failure($sformatf("master AR at %0t ns with no request behind it", $time));
        end else begin
          idx = iss_q.pop_front();
          check_val(mst_ar_addr, pat_addr[idx], "master AR addr");
          check_val(mst_ar_prot, pat_prot[idx], "master AR prot");
          ar_port_seq.push_back(pat_port[idx]);
        end
        idx = find_addr(mst_ar_addr);
        if (idx >= 0) begin
          resp_q.push_back(idx);
        end else begin
          note_failure($sformatf("responder got an unknown address at %0t ns", $time));
        end
      end else if (mst_ar_valid) begin
        ar_wait++;
      end

      check_val(slv_ar_ready & ~slv_ar_valid, '0, "AR ready to an idle port");
      for (p = 0; p < NUM_PORTS; p++) begin
        if (slv_ar_valid[p] && slv_ar_ready[p]) begin
          taken[p] = 1'b1;
          idx = req_q[p].pop_front();
          iss_q.push_back(idx);
          exp_q[p].push_back(idx);
          inflight++;
        end
      end

      // R valid only towards the oldest read
      exp_rv = '0;
      if (mst_r_valid) begin
        exp_rv[pat_port[resp_q[0]]] = 1'b1;
        check_val(mst_r_ready, slv_r_ready[pat_port[resp_q[0]]], "master R ready");
      end
      check_val(slv_r_valid, exp_rv, "R valid steering");
      for (p = 0; p < NUM_PORTS; p++) begin
        if (slv_r_valid[p] && slv_r_ready[p]) begin
          if (exp_q[p].size() == 0) begin
            note_failure($sformatf("port %0d got an R beat it never asked for", p));
          end else begin
            idx = exp_q[p].pop_front();
            check_val(slv_r_data, pat_data[idx], $sformatf("R data on port %0d", p));
            check_val(slv_r_resp, pat_resp[idx], $sformatf("R resp on port %0d", p));
            pending--;
            inflight--;
          end
        end
      end
      if (mst_r_valid && mst_r_ready) begin
        r_taken = 1'b1;
        r_wait  = 0;
        outstanding--;
        idx = resp_q.pop_front();
      end else if (resp_q.size() > 0 && !mst_r_valid) begin
        r_wait++;
      end

      if (outstanding > max_out) begin
        max_out = outstanding;
      end
      if (outstanding > MAX_TRANS) begin
        note_failure($sformatf("more than %0d reads outstanding at the master", MAX_TRANS));
      end
    end

    if (pending > 0) begin
      note_failure($sformatf("timeout in test %0d, %0d reads still pending", test_no, pending));
    end
    // Every run of four ARs covers all ports
    if (test_no == 3) begin
      for (idx = 0; idx + NUM_PORTS <= ar_port_seq.size(); idx++) begin
        seen = '0;
        for (p = 0; p < NUM_PORTS; p++) begin
          seen[ar_port_seq[idx + p]] = 1'b1;
        end
        check_val(seen, {NUM_PORTS{1'b1}}, $sformatf("ports in AR window %0d", idx));
      end
    end
    if (test_no == 5) begin
      check_val(max_out, MAX_TRANS, "peak outstanding reads");
    end
  endtask

  initial begin
    int t;
    int err_before;
    clk        = 1'b0;
    reset      = 1'b1;
    drive_idle();
    err_cnt    = 0;
    check_cnt  = 0;
    fail_tests = 0;
    void'($urandom(6));
    load_patterns();
    for (t = 1; t <= NUM_TESTS; t++) begin
      err_before = err_cnt;
      apply_reset();
      if (t > 1) begin
        run_test(t);
      end
      if (err_cnt == err_before) begin
        $display("test %0d %s: ok", t, test_name(t));
      end else begin
        fail_tests++;
        $display("test %0d %s: FAILED, %0d errors", t, test_name(t), err_cnt - err_before);
      end
    end
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             NUM_TESTS, fail_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/lite_rd_mux.sv */
/*
  AXI4-Lite read multiplexer, NUM_PORTS requesters onto one master.
  AR is round robin and registered; R returns in AR order.
  R data and response are shared by all ports, only valid is steered.
*/
`timescale 1ns/10ps
`default_nettype none

module lite_rd_mux (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  // Requester ports
  input  wire lite_mux_pkg::port_vec_t slv_ar_valid_i,
  input  wire lite_mux_pkg::addr_t     slv_ar_addr_i [lite_mux_pkg::NUM_PORTS],
  input  wire lite_mux_pkg::prot_t     slv_ar_prot_i [lite_mux_pkg::NUM_PORTS],
  output      lite_mux_pkg::port_vec_t slv_ar_ready_o,
  output      lite_mux_pkg::port_vec_t slv_r_valid_o,
  output      lite_mux_pkg::data_t     slv_r_data_o,
  output      lite_mux_pkg::rresp_t    slv_r_resp_o,
  input  wire lite_mux_pkg::port_vec_t slv_r_ready_i,
  // Master port
  output      logic                    mst_ar_valid_o,
  output      lite_mux_pkg::addr_t     mst_ar_addr_o,
  output      lite_mux_pkg::prot_t     mst_ar_prot_o,
  input  wire logic                    mst_ar_ready_i,
  input  wire logic                    mst_r_valid_i,
  input  wire lite_mux_pkg::data_t     mst_r_data_i,
  input  wire lite_mux_pkg::rresp_t    mst_r_resp_i,
  output      logic                    mst_r_ready_o
);
  import lite_mux_pkg::*;

  // Winner index, valid with arb_ar
  port_idx_t arb_idx;

  // Arbiter to tracker
  ar_chan_if arb_ar ();
  // Tracker to spill register
  ar_chan_if out_ar ();

  // ------------------------------
  // AR path
  // ------------------------------
  ar_rr_arbiter ar_rr_arbiter_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .slv_valid_i (slv_ar_valid_i),
    .slv_addr_i  (slv_ar_addr_i),
    .slv_prot_i  (slv_ar_prot_i),
    .slv_ready_o (slv_ar_ready_o),
    .arb_idx_o   (arb_idx),
    .arb_ar_o    (arb_ar.src)
  );

  // Also owns R steering
  rd_order_tracker rd_order_tracker_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .arb_idx_i     (arb_idx),
    .mst_r_valid_i (mst_r_valid_i),
    .slv_r_ready_i (slv_r_ready_i),
    .slv_r_valid_o (slv_r_valid_o),
    .mst_r_ready_o (mst_r_ready_o),
    .arb_ar_i      (arb_ar.dst),
    .out_ar_o      (out_ar.src)
  );

  ar_spill_reg ar_spill_reg_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_addr_o  (mst_ar_addr_o),
    .mst_ar_prot_o  (mst_ar_prot_o),
    .in_ar_i        (out_ar.dst)
  );

  // ------------------------------
  // R payload
  // ------------------------------
  // Same beat seen by every port
  assign slv_r_data_o = mst_r_data_i;
  assign slv_r_resp_o = mst_r_resp_i;

endmodule

`default_nettype wire

/* rtl/ar_spill_reg.sv */
/*
  Two-entry register stage on the outgoing AR channel.
  Adds one cycle of latency and keeps full throughput.
  Input ready depends only on the fill state.
*/
`timescale 1ns/10ps
`default_nettype none

module ar_spill_reg (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                mst_ar_ready_i,
  output      logic                mst_ar_valid_o,
  output      lite_mux_pkg::addr_t mst_ar_addr_o,
  output      lite_mux_pkg::prot_t mst_ar_prot_o,
  ar_chan_if.dst                   in_ar_i
);
  import lite_mux_pkg::*;

  spill_state_e state_q;
  spill_state_e state_d;

  // Slot a drives the output, slot b absorbs a stall
  addr_t a_addr_q;
  prot_t a_prot_q;
  addr_t b_addr_q;
  prot_t b_prot_q;

  logic  in_hs;
  logic  out_hs;
  logic  load_a_in;
  logic  load_a_b;
  logic  load_b;

  assign in_ar_i.ready  = (state_q != SPILL_FULL);
  assign mst_ar_valid_o = (state_q != SPILL_EMPTY);
  assign mst_ar_addr_o  = a_addr_q;
  assign mst_ar_prot_o  = a_prot_q;

  assign in_hs  = in_ar_i.valid & in_ar_i.ready;
  assign out_hs = mst_ar_valid_o & mst_ar_ready_i;

  // ------------------------------
  // Fill control
  // ------------------------------
  always_comb begin
    state_d   = state_q;
    load_a_in = 1'b0;
    load_a_b  = 1'b0;
    load_b    = 1'b0;
    case (state_q)
      SPILL_EMPTY: begin
        if (in_hs) begin
          load_a_in = 1'b1;
          state_d   = SPILL_ONE;
        end
      end
      SPILL_ONE: begin
        // Drained and refilled in one go
        if (in_hs && out_hs) begin
          load_a_in = 1'b1;
        end else if (in_hs) begin
          load_b  = 1'b1;
          state_d = SPILL_FULL;
        end else if (out_hs) begin
          state_d = SPILL_EMPTY;
        end
      end
      SPILL_FULL: begin
        // Older beat leaves, younger moves up
        if (out_hs) begin
          load_a_b = 1'b1;
          state_d  = SPILL_ONE;
        end
      end
      default: state_d = SPILL_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SPILL_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (load_a_in) begin
      a_addr_q <= in_ar_i.addr;
      a_prot_q <= in_ar_i.prot;
    end else if (load_a_b) begin
      a_addr_q <= b_addr_q;
      a_prot_q <= b_prot_q;
    end
    if (load_b) begin
      b_addr_q <= in_ar_i.addr;
      b_prot_q <= in_ar_i.prot;
    end
  end

  // Stalled beat stays put until taken
  a_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mst_ar_valid_o && !mst_ar_ready_i) |=>
      (mst_ar_valid_o && $stable(mst_ar_addr_o) && $stable(mst_ar_prot_o)));

endmodule

`default_nettype wire

/* rtl/rd_order_tracker.sv */
/*
  Keeps read responses in AR order.
  AR is held off while MAX_TRANS reads are outstanding.
  The master side must return exactly one R beat per AR, in order.
*/
`timescale 1ns/10ps
`default_nettype none

module rd_order_tracker (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire lite_mux_pkg::port_idx_t arb_idx_i,
  input  wire logic                    mst_r_valid_i,
  input  wire lite_mux_pkg::port_vec_t slv_r_ready_i,
  output      lite_mux_pkg::port_vec_t slv_r_valid_o,
  output      logic                    mst_r_ready_o,
  ar_chan_if.dst                       arb_ar_i,
  ar_chan_if.src                       out_ar_o
);
  import lite_mux_pkg::*;

  // Route FIFO, winner index per read
  port_idx_t  fifo_q [MAX_TRANS];
  trans_ptr_t rd_ptr_q;
  trans_ptr_t wr_ptr_q;
  trans_cnt_t count_q;

  logic       full;
  logic       empty;
  logic       push;
  logic       pop;
  port_idx_t  head_idx;

  assign full     = (count_q == trans_cnt_t'(MAX_TRANS));
  assign empty    = (count_q == '0);
  assign head_idx = fifo_q[rd_ptr_q];

  // ------------------------------
  // AR gate
  // ------------------------------
  // Full FIFO blocks both directions
  assign out_ar_o.valid = arb_ar_i.valid & ~full;
  assign out_ar_o.addr  = arb_ar_i.addr;
  assign out_ar_o.prot  = arb_ar_i.prot;
  assign arb_ar_i.ready = out_ar_o.ready & ~full;

  assign push = arb_ar_i.valid & arb_ar_i.ready;

  // ------------------------------
  // R steering
  // ------------------------------
  // Valid only towards the head port
  always_comb begin
    slv_r_valid_o = '0;
    if (!empty) begin
      slv_r_valid_o[head_idx] = mst_r_valid_i;
    end
  end

  assign mst_r_ready_o = ~empty & slv_r_ready_i[head_idx];
  assign pop           = mst_r_valid_i & mst_r_ready_o;

  // ------------------------------
  // FIFO state
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == trans_ptr_t'(MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == trans_ptr_t'(MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Index storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= arb_idx_i;
    end
  end

  // Depth must be usable
  a_depth: assert property (@(posedge clk_i) MAX_TRANS > 0);

  // Outstanding reads capped by the depth, count in step with the pointers
  a_count_ptrs: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_q <= trans_cnt_t'(MAX_TRANS)) &&
    (((int'(rd_ptr_q) + int'(count_q)) % MAX_TRANS) == int'(wr_ptr_q)));

  // Master must not answer a read it never saw
  a_no_r_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    empty |-> !mst_r_valid_i);

endmodule

`default_nettype wire

/* rtl/ar_rr_arbiter.sv */
/*
  Round-robin arbiter for the AR channels of all requester ports.
  Grant is combinational and locked while an offered AR waits.
  Requesters must follow AXI and hold valid until accepted.
*/
`timescale 1ns/10ps
`default_nettype none

module ar_rr_arbiter (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire lite_mux_pkg::port_vec_t slv_valid_i,
  input  wire lite_mux_pkg::addr_t     slv_addr_i [lite_mux_pkg::NUM_PORTS],
  input  wire lite_mux_pkg::prot_t     slv_prot_i [lite_mux_pkg::NUM_PORTS],
  output      lite_mux_pkg::port_vec_t slv_ready_o,
  output      lite_mux_pkg::port_idx_t arb_idx_o,
  ar_chan_if.src                       arb_ar_o
);
  import lite_mux_pkg::*;

  // Rotating priority, first port looked at
  port_idx_t rr_ptr_q;
  // Grant held across a stall
  logic      lock_q;
  port_idx_t lock_idx_q;

  // Free-running pick from the pointer
  port_idx_t pick_idx;
  port_idx_t cand_idx;
  logic      any_req;
  port_idx_t grant_idx;
  logic      arb_hs;

  // ------------------------------
  // Pick the next requester
  // ------------------------------
  // Walk from far to near so the
  // nearest requester wins
  always_comb begin
    pick_idx = rr_ptr_q;
    cand_idx = rr_ptr_q;
    any_req  = 1'b0;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      cand_idx = port_idx_t'((int'(rr_ptr_q) + i) % NUM_PORTS);
      if (slv_valid_i[cand_idx]) begin
        pick_idx = cand_idx;
        any_req  = 1'b1;
      end
    end
  end

  // Locked grant overrides a fresh pick
  assign grant_idx = lock_q ? lock_idx_q : pick_idx;

  assign arb_ar_o.valid = lock_q ? slv_valid_i[lock_idx_q] : any_req;
  assign arb_ar_o.addr  = slv_addr_i[grant_idx];
  assign arb_ar_o.prot  = slv_prot_i[grant_idx];
  assign arb_idx_o      = grant_idx;

  assign arb_hs = arb_ar_o.valid & arb_ar_o.ready;

  // Ready back to the winner only
  always_comb begin
    slv_ready_o            = '0;
    slv_ready_o[grant_idx] = arb_hs;
  end

  // ------------------------------
  // Lock and pointer
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // Offered but not taken, hold it
      lock_q     <= arb_ar_o.valid & ~arb_ar_o.ready;
      lock_idx_q <= grant_idx;
      // Winner goes to the back of the line
      if (arb_hs) begin
        rr_ptr_q <= port_idx_t'((int'(grant_idx) + 1) % NUM_PORTS);
      end
    end
  end

  // Port count must fit the index type
  a_port_w: assert property (@(posedge clk_i)
    (NUM_PORTS > 1) && (NUM_PORTS <= (2 ** PORT_W)));

  // One port at a time, and only one offering an AR
  a_one_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(slv_ready_o) && ((slv_ready_o & ~slv_valid_i) == '0));

endmodule

`default_nettype wire

/* rtl/ar_chan_if.sv */
/*
  One AXI4-Lite AR channel between internal stages.
  AXI rules: valid and payload hold until the valid/ready handshake.
*/
`timescale 1ns/10ps
`default_nettype none

interface ar_chan_if;
  import lite_mux_pkg::*;

  // Handshake pair
  logic  valid;
  logic  ready;
  // Payload
  addr_t addr;
  prot_t prot;

  // Producer side
  modport src (
    output valid,
    output addr,
    output prot,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  addr,
    input  prot,
    output ready
  );

endinterface

`default_nettype wire

/* rtl/lite_mux_pkg.sv */
/*
  Sizes and types shared by the AXI4-Lite read multiplexer.
  NUM_PORTS must fit in PORT_W bits, and MAX_TRANS must be at least 1.
  Neither is checked here; the modules that rely on them assert it.
*/
`default_nettype none

package lite_mux_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  // Requester ports sharing the master
  localparam int NUM_PORTS = 4;
  // Outstanding reads, also the route FIFO depth
  localparam int MAX_TRANS = 4;
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int PORT_W    = 2;

  // Route FIFO pointer and fill count widths
  localparam int TRANS_PTR_W = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;
  localparam int TRANS_CNT_W = $clog2(MAX_TRANS + 1);

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [PORT_W-1:0]      port_idx_t;
  typedef logic [NUM_PORTS-1:0]   port_vec_t;
  typedef logic [ADDR_W-1:0]      addr_t;
  // AXI protection bits
  typedef logic [2:0]             prot_t;
  typedef logic [DATA_W-1:0]      data_t;
  // OKAY, EXOKAY, SLVERR, DECERR
  typedef logic [1:0]             rresp_t;
  typedef logic [TRANS_PTR_W-1:0] trans_ptr_t;
  typedef logic [TRANS_CNT_W-1:0] trans_cnt_t;

  // Fill level of the AR spill register
  typedef enum logic [1:0] {
    SPILL_EMPTY,
    SPILL_ONE,
    SPILL_FULL
  } spill_state_e;

endpackage

`default_nettype wire
